//--- Bender.yml
package:
  name: cpu_core

sources:
  - src/global_variables.sv
  - src/structures.sv
  - src/rename_stage.sv
  - src/reservation_station.sv
  - src/alu_exec.sv
  - src/mult_exec.sv
  - src/cdb_arbiter.sv
  - src/reorder_buffer.sv
  - src/cpu_core.sv
  - target: simulation
    files:
      - dv/cpu_core_assertions.sv
      - dv/cpu_core_tb.sv

//--- cpu_core.f
src/global_variables.sv
src/structures.sv
src/rename_stage.sv
src/reservation_station.sv
src/alu_exec.sv
src/mult_exec.sv
src/cdb_arbiter.sv
src/reorder_buffer.sv
src/cpu_core.sv
dv/cpu_core_assertions.sv
dv/cpu_core_tb.sv

//--- dv/cpu_core_assertions.sv
`timescale 1ns/1ps

module cpu_core_assertions (
  input logic clock,
  input logic reset,
  input logic full,
  input structures::commit_t commit,
  input structures::fu_result_t mult_result,
  input logic mult_grant,
  input structures::cdb_t cdb,
  input logic [global_variables::ROB_DEPTH-1:0] rob_done,
  input logic [global_variables::ROB_TAG_WIDTH:0] rob_count
);
  import global_variables::*;

  int failures = 0;

  // The first reset edge only starts clearing state, so check from the second one
  quiet_in_reset: assert property (@(posedge clock)
    reset && $past(reset) |-> !full && !commit.valid)
    else begin
      failures++;
      $error("full or commit.valid high during reset");
    end

  // A product that loses the bus waits unchanged in the last stage
  mult_held: assert property (@(posedge clock) disable iff (reset)
    mult_result.valid && !mult_grant |=> mult_result.valid && $stable(mult_result))
    else begin
      failures++;
      $error("A multiplier result that was not granted did not hold");
    end

  bus_pending: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> !rob_done[cdb.tag]) // Each tag is broadcast once per allocation
    else begin
      failures++;
      $error("The data bus broadcast a tag that was already done");
    end

  rob_bounded: assert property (@(posedge clock) disable iff (reset) rob_count <= ROB_DEPTH)
    else begin
      failures++;
      $error("Reorder buffer count exceeds its depth");
    end

endmodule

bind cpu_core cpu_core_assertions u_assertions (
  .clock(clock),
  .reset(reset),
  .full(full),
  .commit(commit),
  .mult_result(mult_result),
  .mult_grant(mult_grant),
  .cdb(cdb),
  .rob_done(u_rob.done),
  .rob_count(u_rob.count)
);

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
  import global_variables::*;
  import structures::*;

  localparam int WAIT_LIMIT = 200;
  localparam int DRAIN_LIMIT = 2000;

  typedef struct packed {
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [ROB_TAG_WIDTH-1:0] tag;
    logic [XLEN-1:0] value;
  } expect_t;

  logic clock;
  logic reset;
  logic issue_valid;
  instr_t issue_instr;
  logic full;
  commit_t commit;

  logic [XLEN-1:0] model_regs [REG_COUNT];
  expect_t expected_q [$]; // Oldest instruction first
  int issued;
  bit full_seen;
  string test_name;

  cpu_core u_dut (
    .clock(clock),
    .reset(reset),
    .issue_valid(issue_valid),
    .issue_instr(issue_instr),
    .full(full),
    .commit(commit)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_value(input string what, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("Simulation FAILED");
    $fatal(1, "Timeout");
  endtask

  task automatic next_cycle;
    @(posedge clock);
    #1;
  endtask

  // Reference result computed from the model registers in program order
  function automatic logic [XLEN-1:0] expected_result(input instr_t instr);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic signed [2*XLEN-1:0] prod;
    a = model_regs[instr.rs1];
    b = instr.use_imm ? {{(XLEN - 8){instr.imm[7]}}, instr.imm} : model_regs[instr.rs2];
    prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    case (instr.op)
      op_add: return a + b;
      op_sub: return a - b;
      op_and: return a & b;
      op_or: return a | b;
      op_xor: return a ^ b;
      op_sll: return a << b[4:0];
      op_slt: return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      op_mul: return prod[XLEN-1:0];
      op_mulh: return prod[2*XLEN-1:XLEN];
      default: return '0;
    endcase
  endfunction

  function automatic instr_t random_instr(input int mul_percent, input int reg_span);
    instr_t instr;
    if ($urandom_range(99) < mul_percent) begin
      instr.op = ($urandom_range(1) == 0) ? op_mul : op_mulh;
    end else begin
      instr.op = op_t'($urandom_range(6));
    end
    instr.rd = REG_ADDR_WIDTH'($urandom_range(reg_span));
    instr.rs1 = REG_ADDR_WIDTH'($urandom_range(reg_span));
    instr.rs2 = REG_ADDR_WIDTH'($urandom_range(reg_span));
    instr.use_imm = ($urandom_range(3) == 0);
    instr.imm = 8'($urandom());
    return instr;
  endfunction

  task automatic drive_issue(input instr_t instr);
    expect_t item;
    issue_valid = 1'b1;
    issue_instr = instr;
    item.rd = instr.rd;
    item.tag = ROB_TAG_WIDTH'(issued); // Tags go round the buffer in issue order
    item.value = expected_result(instr);
    expected_q.push_back(item);
    if (instr.rd != '0) model_regs[instr.rd] = item.value; // Register 0 stays zero
    issued++;
  endtask

  task automatic issue_one(input instr_t instr);
    int waited;
    waited = 0;
    while (full) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("full stayed high while waiting to issue");
    end
    drive_issue(instr);
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic random_traffic(input int cycles, input int mul_percent);
    for (int c = 0; c < cycles; c++) begin
      if ($urandom_range(99) < 70 && !full) drive_issue(random_instr(mul_percent, 7));
      else issue_valid = 1'b0;
      next_cycle();
    end
    issue_valid = 1'b0;
  endtask

  // Each instruction reads the previous result while mul and ALU work alternate
  task automatic dependent_chain(input int length);
    instr_t instr;
    logic [REG_ADDR_WIDTH-1:0] prev_rd;
    prev_rd = REG_ADDR_WIDTH'($urandom_range(1, 7));
    for (int k = 0; k < length; k++) begin
      instr = random_instr((k % 2 == 0) ? 100 : 0, 7);
      instr.rs1 = prev_rd;
      if (instr.rd == '0) instr.rd = 5'd1;
      issue_one(instr);
      prev_rd = instr.rd;
    end
  endtask

  task automatic zero_register_sequence;
    instr_t instr;
    instr = '0;
    instr.op = op_add;
    instr.rs1 = 5'd1;
    instr.use_imm = 1'b1;
    instr.imm = 8'h5a;
    issue_one(instr); // Commits a nonzero value with rd 0
    instr.op = op_or;
    instr.rd = 5'd4;
    instr.rs1 = 5'd0;
    instr.use_imm = 1'b0;
    issue_one(instr);
    instr.op = op_mul;
    instr.rd = 5'd0;
    instr.rs1 = 5'd2;
    instr.rs2 = 5'd3;
    issue_one(instr);
    instr.op = op_add;
    instr.rd = 5'd5;
    instr.rs1 = 5'd0;
    instr.use_imm = 1'b1;
    instr.imm = 8'h81;
    issue_one(instr);
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > DRAIN_LIMIT) report_timeout("commits did not drain");
    end
  endtask

  always @(negedge clock) begin
    expect_t item;
    if (u_dut.u_assertions.failures != 0) begin
      $display("An assertion in the DUT failed during %s", test_name);
      $display("Simulation FAILED");
      $fatal(1, "Assertion failure");
    end else if (!reset) begin
      if (full) full_seen = 1'b1;
      if (commit.valid) begin
        if (expected_q.size() == 0) begin
          $display("A commit arrived in %s with no instruction outstanding", test_name);
          $display("Simulation FAILED");
          $fatal(1, "Unexpected commit");
        end else begin
          item = expected_q.pop_front();
          check_value("commit rd", item.rd, commit.rd);
          check_value("commit tag", item.tag, commit.tag);
          check_value("commit value", item.value, commit.value);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h854a));
    reset = 1'b1;
    issue_valid = 1'b0;
    issue_instr = '0;
    issued = 0;
    full_seen = 1'b0;
    test_name = "reset";
    for (int r = 0; r < REG_COUNT; r++) model_regs[r] = '0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    test_name = "random_stream";
    random_traffic(600, 40);
    wait_drain();

    test_name = "dependent_chains";
    repeat (6) dependent_chain(12);
    wait_drain();

    test_name = "register_zero";
    zero_register_sequence();
    wait_drain();

    // Few registers, so products wait on each other and the stations fill
    test_name = "mul_stream";
    full_seen = 1'b0;
    for (int k = 0; k < 80; k++) issue_one(random_instr(90, 3));
    wait_drain();
    check_value("full rose", 1, full_seen);

    test_name = "final_drain";
    check_value("full after drain", 0, full);
    if (u_dut.u_assertions.failures == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures were flagged", u_dut.u_assertions.failures);
      $display("Simulation FAILED");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

//--- src/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input logic clock,
  input logic reset,
  input logic dispatch_valid,
  input structures::alu_rs_entry_t dispatch_entry,
  output logic dispatch_accept,
  input logic grant,
  output structures::fu_result_t result
);
  import global_variables::*;
  import structures::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] value;

  assign a = dispatch_entry.base.src1.value;
  assign b = dispatch_entry.base.src2.value;

  always_comb begin
    case (dispatch_entry.op)
      alu_add: value = a + b;
      alu_sub: value = a - b;
      alu_and: value = a & b;
      alu_or: value = a | b;
      alu_xor: value = a ^ b;
      alu_sll: value = a << b[$clog2(XLEN)-1:0];
      alu_slt: value = {{(XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
      default: value = '0;
    endcase
  end

  // Result register frees up in the same cycle it wins the bus
  assign dispatch_accept = !result.valid || grant;

  always_ff @(posedge clock) begin
    if (reset) result.valid <= 1'b0;
    else if (dispatch_accept) result.valid <= dispatch_valid;
    if (dispatch_accept && dispatch_valid) begin
      result.tag <= dispatch_entry.base.dest;
      result.value <= value;
    end
  end

endmodule

//--- src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
  input structures::fu_result_t alu_result,
  input structures::fu_result_t mult_result,
  output logic alu_grant,
  output logic mult_grant,
  output structures::cdb_t cdb
);

  // ALU first, its single-cycle results would otherwise pile up behind products
  assign alu_grant = alu_result.valid;
  assign mult_grant = mult_result.valid && !alu_result.valid;

  always_comb begin
    cdb.valid = alu_grant || mult_grant;
    if (alu_grant) begin
      cdb.tag = alu_result.tag;
      cdb.value = alu_result.value;
    end else begin
      cdb.tag = mult_result.tag;
      cdb.value = mult_result.value;
    end
  end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input logic clock,
  input logic reset,
  input logic issue_valid,
  input structures::instr_t issue_instr,
  output logic full,
  output structures::commit_t commit
);
  import global_variables::*;
  import structures::*;

  logic rob_full;
  logic alu_rs_full;
  logic mult_rs_full;
  logic [ROB_TAG_WIDTH-1:0] next_tag;
  logic [ROB_TAG_WIDTH-1:0] rob_query_tag [2];
  logic [XLEN-1:0] rob_query_value [2];
  logic rob_query_ready [2];

  logic alu_write;
  logic mult_write;
  alu_rs_entry_t alu_entry;
  mult_rs_entry_t mult_entry;

  logic alu_dispatch_valid;
  logic alu_dispatch_accept;
  alu_rs_entry_t alu_dispatch_entry;
  logic mult_dispatch_valid;
  logic mult_dispatch_accept;
  mult_rs_entry_t mult_dispatch_entry;

  fu_result_t alu_result;
  fu_result_t mult_result;
  logic alu_grant;
  logic mult_grant;
  cdb_t cdb;

  rename_stage u_rename (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_instr(issue_instr),
    .rob_full(rob_full), .alu_rs_full(alu_rs_full), .mult_rs_full(mult_rs_full),
    .next_tag(next_tag),
    .rob_query_tag(rob_query_tag), .rob_query_value(rob_query_value),
    .rob_query_ready(rob_query_ready),
    .cdb(cdb), .commit(commit),
    .alu_write(alu_write), .alu_entry(alu_entry),
    .mult_write(mult_write), .mult_entry(mult_entry),
    .full(full)
  );

  reservation_station #(.entry_t(alu_rs_entry_t), .DEPTH(ALU_RS_DEPTH)) u_alu_rs (
    .clock(clock), .reset(reset),
    .write(alu_write), .entry_in(alu_entry), .cdb(cdb), .full(alu_rs_full),
    .dispatch_valid(alu_dispatch_valid), .dispatch_entry(alu_dispatch_entry),
    .dispatch_accept(alu_dispatch_accept)
  );

  reservation_station #(.entry_t(mult_rs_entry_t), .DEPTH(MULT_RS_DEPTH)) u_mult_rs (
    .clock(clock), .reset(reset),
    .write(mult_write), .entry_in(mult_entry), .cdb(cdb), .full(mult_rs_full),
    .dispatch_valid(mult_dispatch_valid), .dispatch_entry(mult_dispatch_entry),
    .dispatch_accept(mult_dispatch_accept)
  );

  alu_exec u_alu (
    .clock(clock), .reset(reset),
    .dispatch_valid(alu_dispatch_valid), .dispatch_entry(alu_dispatch_entry),
    .dispatch_accept(alu_dispatch_accept), .grant(alu_grant), .result(alu_result)
  );

  mult_exec u_mult (
    .clock(clock), .reset(reset),
    .dispatch_valid(mult_dispatch_valid), .dispatch_entry(mult_dispatch_entry),
    .dispatch_accept(mult_dispatch_accept), .grant(mult_grant), .result(mult_result)
  );

  cdb_arbiter u_arbiter (
    .alu_result(alu_result), .mult_result(mult_result),
    .alu_grant(alu_grant), .mult_grant(mult_grant), .cdb(cdb)
  );

  reorder_buffer u_rob (
    .clock(clock), .reset(reset),
    .alloc(issue_valid), .alloc_rd(issue_instr.rd), // Every issue takes a ROB entry
    .next_tag(next_tag), .full(rob_full), .cdb(cdb),
    .query_tag(rob_query_tag), .query_value(rob_query_value),
    .query_ready(rob_query_ready),
    .commit(commit)
  );

endmodule

//--- src/global_variables.sv
package global_variables;

  localparam int XLEN = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // Tags index the reorder buffer directly, so depth is 2**ROB_TAG_WIDTH
  localparam int ROB_DEPTH = 8;
  localparam int ROB_TAG_WIDTH = 3;

  localparam int ALU_RS_DEPTH = 4;
  localparam int MULT_RS_DEPTH = 2;
  localparam int MULT_STAGES = 3;

endpackage

//--- src/mult_exec.sv
`timescale 1ns/1ps

module mult_exec (
  input logic clock,
  input logic reset,
  input logic dispatch_valid,
  input structures::mult_rs_entry_t dispatch_entry,
  output logic dispatch_accept,
  input logic grant,
  output structures::fu_result_t result
);
  import global_variables::*;
  import structures::*;

  localparam int LAST = MULT_STAGES - 1;

  typedef struct packed {
    logic [ROB_TAG_WIDTH-1:0] tag;
    mult_op_t op;
    logic [2*XLEN-1:0] product;
  } stage_t;

  logic [MULT_STAGES-1:0] stage_valid;
  stage_t stage [MULT_STAGES];
  logic signed [2*XLEN-1:0] product;
  logic advance;

  assign product = $signed(dispatch_entry.base.src1.value)
                 * $signed(dispatch_entry.base.src2.value);

  // The whole pipe freezes while the last product waits for the bus
  assign advance = !(stage_valid[LAST] && !grant);
  assign dispatch_accept = advance;

  always_ff @(posedge clock) begin
    if (reset) stage_valid <= '0;
    else if (advance) stage_valid <= {stage_valid[LAST-1:0], dispatch_valid};
    if (advance) begin
      stage[0] <= '{tag: dispatch_entry.base.dest, op: dispatch_entry.op, product: product};
      for (int k = 1; k < MULT_STAGES; k++) stage[k] <= stage[k-1];
    end
  end

  assign result.valid = stage_valid[LAST];
  assign result.tag = stage[LAST].tag;
  assign result.value = (stage[LAST].op == mult_mulh) ? stage[LAST].product[2*XLEN-1:XLEN]
                                                       : stage[LAST].product[XLEN-1:0];

endmodule

//--- src/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
  input logic clock,
  input logic reset,
  input logic issue_valid,
  input structures::instr_t issue_instr,
  input logic rob_full,
  input logic alu_rs_full,
  input logic mult_rs_full,
  input logic [global_variables::ROB_TAG_WIDTH-1:0] next_tag,
  output logic [global_variables::ROB_TAG_WIDTH-1:0] rob_query_tag [2],
  input logic [global_variables::XLEN-1:0] rob_query_value [2],
  input logic rob_query_ready [2],
  input structures::cdb_t cdb,
  input structures::commit_t commit,
  output logic alu_write,
  output structures::alu_rs_entry_t alu_entry,
  output logic mult_write,
  output structures::mult_rs_entry_t mult_entry,
  output logic full
);
  import global_variables::*;
  import structures::*;

  logic [XLEN-1:0] regs [REG_COUNT];
  logic [REG_COUNT-1:0] busy;
  logic [ROB_TAG_WIDTH-1:0] reg_tag [REG_COUNT];

  logic [REG_ADDR_WIDTH-1:0] src_reg [2];
  operand_t src [2];
  rs_entry_t base_entry;
  alu_op_t alu_op;
  logic is_mult;

  assign src_reg[0] = issue_instr.rs1;
  assign src_reg[1] = issue_instr.rs2;

  always_comb begin : resolve_operands
    for (int i = 0; i < 2; i++) begin
      rob_query_tag[i] = reg_tag[src_reg[i]];
      src[i].tag = reg_tag[src_reg[i]];
      src[i].ready = 1'b1;
      if (!busy[src_reg[i]]) begin
        src[i].value = regs[src_reg[i]];
      end else if (rob_query_ready[i]) begin
        src[i].value = rob_query_value[i]; // Done but not yet committed
      end else if (cdb.valid && cdb.tag == reg_tag[src_reg[i]]) begin
        src[i].value = cdb.value;
      end else begin
        src[i].ready = 1'b0;
        src[i].value = '0;
      end
    end
    if (issue_instr.use_imm) begin
      src[1].ready = 1'b1;
      src[1].value = {{(XLEN - 8){issue_instr.imm[7]}}, issue_instr.imm};
    end
  end

  always_comb begin
    case (issue_instr.op)
      op_sub: alu_op = alu_sub;
      op_and: alu_op = alu_and;
      op_or: alu_op = alu_or;
      op_xor: alu_op = alu_xor;
      op_sll: alu_op = alu_sll;
      op_slt: alu_op = alu_slt;
      default: alu_op = alu_add;
    endcase
  end

  assign is_mult = issue_instr.op == op_mul || issue_instr.op == op_mulh;
  assign base_entry = '{dest: next_tag, src1: src[0], src2: src[1]};
  assign alu_entry = '{base: base_entry, op: alu_op};
  assign mult_entry = '{base: base_entry, op: (issue_instr.op == op_mulh) ? mult_mulh : mult_mul};
  assign alu_write = issue_valid && !is_mult;
  assign mult_write = issue_valid && is_mult;
  assign full = rob_full || alu_rs_full || mult_rs_full;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      regs <= '{default: '0};
    end else begin
      if (commit.valid) begin
        if (commit.rd != '0) regs[commit.rd] <= commit.value;
        // A newer rename of the same register keeps it busy
        if (reg_tag[commit.rd] == commit.tag) busy[commit.rd] <= 1'b0;
      end
      if (issue_valid && issue_instr.rd != '0) begin // Placed last so issue beats commit
        busy[issue_instr.rd] <= 1'b1;
        reg_tag[issue_instr.rd] <= next_tag;
      end
    end
  end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
  input logic clock,
  input logic reset,
  input logic alloc,
  input logic [global_variables::REG_ADDR_WIDTH-1:0] alloc_rd,
  output logic [global_variables::ROB_TAG_WIDTH-1:0] next_tag,
  output logic full,
  input structures::cdb_t cdb,
  input logic [global_variables::ROB_TAG_WIDTH-1:0] query_tag [2],
  output logic [global_variables::XLEN-1:0] query_value [2],
  output logic query_ready [2],
  output structures::commit_t commit
);
  import global_variables::*;

  logic [ROB_TAG_WIDTH-1:0] head;
  logic [ROB_TAG_WIDTH-1:0] tail; // Pointers wrap on their own
  logic [ROB_TAG_WIDTH:0] count;
  logic [ROB_DEPTH-1:0] done;
  logic [REG_ADDR_WIDTH-1:0] entry_rd [ROB_DEPTH];
  logic [XLEN-1:0] entry_value [ROB_DEPTH];
  logic retire;

  assign next_tag = tail;
  assign full = (count == ROB_DEPTH);
  assign retire = (count != '0) && done[head];

  // Done stays set after commit, so a value is still found until the slot is reused
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      query_ready[i] = done[query_tag[i]];
      query_value[i] = entry_value[query_tag[i]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
      commit.valid <= 1'b0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (cdb.valid) done[cdb.tag] <= 1'b1;
      if (retire) head <= head + 1'b1;
      case ({alloc, retire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      commit.valid <= retire;
    end
    if (alloc) entry_rd[tail] <= alloc_rd;
    if (cdb.valid) entry_value[cdb.tag] <= cdb.value;
    if (retire) begin
      commit.rd <= entry_rd[head];
      commit.tag <= head;
      commit.value <= entry_value[head];
    end
  end

endmodule

//--- src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  type entry_t = structures::alu_rs_entry_t,
  parameter int DEPTH = 4
) (
  input logic clock,
  input logic reset,
  input logic write,
  input entry_t entry_in,
  input structures::cdb_t cdb,
  output logic full,
  output logic dispatch_valid,
  output entry_t dispatch_entry,
  input logic dispatch_accept
);
  import structures::*;

  localparam int IDX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Entries stay packed toward index 0, which is always the oldest
  entry_t entries [DEPTH];
  entry_t entries_next [DEPTH];
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;
  logic [IDX_WIDTH-1:0] sel_idx;
  logic sel_valid;
  logic pop;

  function automatic operand_t snoop(operand_t src, cdb_t bus);
    operand_t captured;
    captured = src;
    if (bus.valid && !src.ready && src.tag == bus.tag) begin
      captured.ready = 1'b1;
      captured.value = bus.value;
    end
    return captured;
  endfunction

  always_comb begin : pick_oldest
    sel_valid = 1'b0;
    sel_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (valid[i] && entries[i].base.src1.ready && entries[i].base.src2.ready) begin
        sel_valid = 1'b1;
        sel_idx = IDX_WIDTH'(i);
      end
    end
  end

  assign dispatch_valid = sel_valid;
  assign dispatch_entry = entries[sel_idx];
  assign pop = sel_valid && dispatch_accept;
  assign full = &valid;

  always_comb begin
    logic placed;
    entries_next = entries;
    valid_next = valid;
    placed = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      entries_next[i].base.src1 = snoop(entries[i].base.src1, cdb);
      entries_next[i].base.src2 = snoop(entries[i].base.src2, cdb);
    end
    if (pop) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        if (i >= sel_idx) begin
          entries_next[i] = entries_next[i + 1];
          valid_next[i] = valid_next[i + 1];
        end
      end
      valid_next[DEPTH-1] = 1'b0;
    end
    for (int i = 0; i < DEPTH; i++) begin
      if (write && !placed && !valid_next[i]) begin
        entries_next[i] = entry_in; // Already resolved against this cycle's bus
        valid_next[i] = 1'b1;
        placed = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) valid <= '0;
    else valid <= valid_next;
    entries <= entries_next;
  end

endmodule

//--- src/structures.sv
package structures;

  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_xor, op_sll, op_slt, op_mul, op_mulh
  } op_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_slt
  } alu_op_t;

  typedef enum logic {mult_mul, mult_mulh} mult_op_t;

  typedef struct packed {
    op_t op;
    logic [global_variables::REG_ADDR_WIDTH-1:0] rd;
    logic [global_variables::REG_ADDR_WIDTH-1:0] rs1;
    logic [global_variables::REG_ADDR_WIDTH-1:0] rs2;
    logic use_imm; // Replaces rs2 with imm
    logic [7:0] imm;
  } instr_t;

  typedef struct packed {
    logic ready;
    logic [global_variables::ROB_TAG_WIDTH-1:0] tag; // Producer while not ready
    logic [global_variables::XLEN-1:0] value;
  } operand_t;

  // Fields common to every station, the payload is added per unit
  typedef struct packed {
    logic [global_variables::ROB_TAG_WIDTH-1:0] dest;
    operand_t src1;
    operand_t src2;
  } rs_entry_t;

  typedef struct packed {
    rs_entry_t base;
    alu_op_t op;
  } alu_rs_entry_t;

  typedef struct packed {
    rs_entry_t base;
    mult_op_t op;
  } mult_rs_entry_t;

  typedef struct packed {
    logic valid;
    logic [global_variables::ROB_TAG_WIDTH-1:0] tag;
    logic [global_variables::XLEN-1:0] value;
  } fu_result_t;

  typedef struct packed {
    logic valid;
    logic [global_variables::ROB_TAG_WIDTH-1:0] tag;
    logic [global_variables::XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic valid;
    logic [global_variables::REG_ADDR_WIDTH-1:0] rd;
    logic [global_variables::ROB_TAG_WIDTH-1:0] tag;
    logic [global_variables::XLEN-1:0] value;
  } commit_t;

endpackage
